// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= l2d_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

PASS_MSG  := Test completed successfully

.PHONY: sim clean

# build, run, and pass only when the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+.
l2d_pkg.sv
l2d_ecc39.sv
l2d_deccdp.sv
l2d_decc_ctl.sv
l2d_err_log.sv
l2d_ret_top.sv
l2d_tb_clkgen.sv
l2d_tb.sv

// ==== l2d_decc_ctl.sv ====
// read valid pipeline and per-read ce/ue classification from the four lane syndromes
`timescale 1ns/1ps
`default_nettype none

`include "l2d_params.svh"

module l2d_decc_ctl (
  input  logic                                  rclk,
  input  logic                                  arst_n,
  input  logic                                  rd_vld_c7,
  input  l2d_pkg::lane_synd_t [`L2D_LANES-1:0]  lane_synd_c7,
  output logic                                  ret_vld_c8,
  output logic                                  ce_c8,
  output logic                                  ue_c8
);

  // parity flag set means exactly one flip, check flags alone mean two
  function automatic l2d_pkg::err_class_t classify(input l2d_pkg::lane_synd_t s);
    l2d_pkg::err_class_t c;
    if (s.parity) begin
      c = l2d_pkg::ERR_CE;
    end else if (s.check != '0) begin
      c = l2d_pkg::ERR_UE;
    end else begin
      c = l2d_pkg::ERR_NONE;
    end
    return c;
  endfunction

  l2d_pkg::err_class_t lane_class_c7 [`L2D_LANES];
  l2d_pkg::err_class_t rd_class_c7;

  ////////////////////////////////////////////////////////////////////////////
  // c7 combine
  ////////////////////////////////////////////////////////////////////////////

  // any ue wins, otherwise any ce
  always_comb begin
    rd_class_c7 = l2d_pkg::ERR_NONE;
    for (int l = 0; l < `L2D_LANES; l++) begin
      lane_class_c7[l] = classify(lane_synd_c7[l]);
      if (lane_class_c7[l] == l2d_pkg::ERR_UE) begin
        rd_class_c7 = l2d_pkg::ERR_UE;
      end else if (lane_class_c7[l] == l2d_pkg::ERR_CE &&
                   rd_class_c7 == l2d_pkg::ERR_NONE) begin
        rd_class_c7 = l2d_pkg::ERR_CE;
      end
    end
  end

  // c8 strobes, qualified by valid so idle cycles never flag
  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      ret_vld_c8 <= 1'b0;
      ce_c8      <= 1'b0;
      ue_c8      <= 1'b0;
    end else begin
      ret_vld_c8 <= rd_vld_c7;
      ce_c8      <= rd_vld_c7 && (rd_class_c7 == l2d_pkg::ERR_CE);
      ue_c8      <= rd_vld_c7 && (rd_class_c7 == l2d_pkg::ERR_UE);
    end
  end

  // a read is ce or ue, never both
  a_ce_ue_excl: assert property (@(posedge rclk) disable iff (!arst_n)
    !(ce_c8 && ue_c8))
    else $error("ce_c8 and ue_c8 set together");

  // error strobes only ride on a returned read
  a_err_has_vld: assert property (@(posedge rclk) disable iff (!arst_n)
    (ce_c8 || ue_c8) |-> ret_vld_c8)
    else $error("error strobe without ret_vld_c8");

endmodule

`default_nettype wire

// ==== l2d_deccdp.sv ====
// c7/c8 return datapath: lane correction, return flops, doubleword and diagnostic muxes
`timescale 1ns/1ps
`default_nettype none

`include "l2d_params.svh"

module l2d_deccdp (
  input  logic                                  rclk,
  input  logic [`L2D_DATA_W-1:0]                rd_data_c7,
  input  logic [`L2D_ECC_W-1:0]                 rd_ecc_c7,
  input  logic                                  dword_sel_c7,
  input  logic                                  sel_higher_word_c7,
  input  logic                                  sel_higher_dword_c7,
  output logic [`L2D_DATA_W-1:0]                ret_data_c8,
  output logic [`L2D_DWORD_W-1:0]               arb_data_c8,
  output logic [`L2D_WORD_W-1:0]                diag_data_c7,
  output l2d_pkg::lane_synd_t [`L2D_LANES-1:0]  lane_synd_c7,
  output logic [`L2D_ECC_W-1:0]                 lda_syndrome_c9
);

  localparam int DW = `L2D_LANE_DATA_W;
  localparam int EW = `L2D_LANE_ECC_W;

  // raw codewords, index is the lane number
  logic [`L2D_WORD_W-1:0]  word_c7 [`L2D_LANES];
  logic [`L2D_DATA_W-1:0]  corr_data_c7;
  logic [`L2D_ECC_W-1:0]   error_synd_c7;
  logic [`L2D_ECC_W-1:0]   error_synd_c8;
  logic                    dword_sel_c8;
  logic [`L2D_WORD_W-1:0]  left_diag_c7;
  logic [`L2D_WORD_W-1:0]  rgt_diag_c7;

  ////////////////////////////////////////////////////////////////////////////
  // c7 lane correction
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < `L2D_LANES; l++) begin : g_lane
    // lane l owns data 32l+31..32l and ecc 7l+6..7l
    assign word_c7[l] = {rd_data_c7[l*DW +: DW], rd_ecc_c7[l*EW +: EW]};

    l2d_ecc39 u_ecc (
      .word (word_c7[l]),
      .data (corr_data_c7[l*DW +: DW]),
      .synd (lane_synd_c7[l])
    );
  end

  // lane 3 lands in bits 27:21, lane 0 in 6:0
  assign error_synd_c7 = lane_synd_c7;

  ////////////////////////////////////////////////////////////////////////////
  // c8 return and c9 syndrome flops
  ////////////////////////////////////////////////////////////////////////////

  // syndrome runs every cycle whether or not the read was valid
  always_ff @(posedge rclk) begin
    ret_data_c8     <= corr_data_c7;
    dword_sel_c8    <= dword_sel_c7;
    error_synd_c8   <= error_synd_c7;
    lda_syndrome_c9 <= error_synd_c8;
  end

  // store/scrub doubleword from corrected data
  // select 0 takes the upper half
  assign arb_data_c8 = dword_sel_c8 ? ret_data_c8[`L2D_DWORD_W-1:0]
                                    : ret_data_c8[`L2D_DATA_W-1:`L2D_DWORD_W];

  ////////////////////////////////////////////////////////////////////////////
  // diagnostic mux on uncorrected c7 words
  ////////////////////////////////////////////////////////////////////////////

  // first level picks within a pair
  assign left_diag_c7 = sel_higher_word_c7 ? word_c7[2] : word_c7[3];
  assign rgt_diag_c7  = sel_higher_word_c7 ? word_c7[0] : word_c7[1];

  // second level picks the pair, low means lanes 3/2
  assign diag_data_c7 = sel_higher_dword_c7 ? rgt_diag_c7 : left_diag_c7;

endmodule

`default_nettype wire

// ==== l2d_ecc39.sv ====
// sec-ded check and single-bit correction of one 39-bit codeword, instanced once per lane
`timescale 1ns/1ps
`default_nettype none

`include "l2d_params.svh"

module l2d_ecc39 (
  // codeword as {data[31:0], ecc[6:0]}
  input  logic [`L2D_WORD_W-1:0]      word,
  output logic [`L2D_LANE_DATA_W-1:0] data,
  output l2d_pkg::lane_synd_t         synd
);

  localparam int DW = `L2D_LANE_DATA_W;
  localparam int EW = `L2D_LANE_ECC_W;
  // hamming check flags exclude the overall parity bit
  localparam int CW = EW - 1;

  // hamming position of data bit idx
  // data fills the positions 1..38 that are not powers of two, in ascending order
  function automatic logic [CW-1:0] data_pos(input int idx);
    int            seen;
    logic [CW-1:0] pos;
    seen = 0;
    pos  = '0;
    for (int q = 1; q < `L2D_WORD_W; q++) begin
      if ((q & (q - 1)) != 0) begin
        if (seen == idx) begin
          pos = q[CW-1:0];
        end
        seen++;
      end
    end
    return pos;
  endfunction

  logic [DW-1:0] raw;
  logic [EW-1:0] ecc;
  logic [CW-1:0] term [DW];
  logic [CW-1:0] check;
  logic          parity;

  assign raw = word[`L2D_WORD_W-1:EW];
  assign ecc = word[EW-1:0];

  for (genvar i = 0; i < DW; i++) begin : g_bit
    localparam logic [CW-1:0] POS = data_pos(i);
    // a set data bit contributes its position to the check flags
    assign term[i] = raw[i] ? POS : '0;
    // flip only on a single error that names this bit
    assign data[i] = raw[i] ^ (parity && (check == POS));
  end

  // check bit k sits at position 2^k, so it only touches flag bit k
  always_comb begin
    check = ecc[CW-1:0];
    for (int i = 0; i < DW; i++) begin
      check = check ^ term[i];
    end
  end

  // ecc bit 6 makes the whole word even, so any odd count of flips shows here
  assign parity = ^word;

  // single errors on check or parity positions leave the data untouched
  assign synd = {parity, check};

endmodule

`default_nettype wire

// ==== l2d_err_log.sv ====
// sticky first-error syndrome log for the status block, ue has priority and err_clr empties it
`timescale 1ns/1ps
`default_nettype none

`include "l2d_params.svh"

module l2d_err_log (
  input  logic                   rclk,
  input  logic                   arst_n,
  input  logic                   ce_c8,
  input  logic                   ue_c8,
  input  logic                   err_clr,
  input  logic [`L2D_ECC_W-1:0]  lda_syndrome_c9,
  output logic                   log_ce,
  output logic                   log_ue,
  output logic [`L2D_ECC_W-1:0]  log_synd
);

  logic                  take_ce;
  logic                  take_ue;
  // c9 copy of the capture decision, lines up with lda_syndrome_c9
  logic                  cap_c9;
  logic [`L2D_ECC_W-1:0] held_synd;

  // ue replaces an empty or ce log, ce only fills an empty one
  assign take_ue = ue_c8 && !log_ue;
  assign take_ce = ce_c8 && !log_ce && !log_ue;

  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      log_ce    <= 1'b0;
      log_ue    <= 1'b0;
      cap_c9    <= 1'b0;
      held_synd <= '0;
    end else if (err_clr) begin
      // clear beats any capture in the same cycle
      log_ce    <= 1'b0;
      log_ue    <= 1'b0;
      cap_c9    <= 1'b0;
      held_synd <= '0;
    end else begin
      cap_c9 <= take_ue || take_ce;
      // park the syndrome one cycle after it was taken
      if (cap_c9) begin
        held_synd <= lda_syndrome_c9;
      end
      if (take_ue) begin
        log_ue <= 1'b1;
        log_ce <= 1'b0;
      end else if (take_ce) begin
        log_ce <= 1'b1;
      end
    end
  end

  // fresh capture shows the live c9 syndrome, later the parked copy
  assign log_synd = cap_c9 ? lda_syndrome_c9 : held_synd;

  a_log_excl: assert property (@(posedge rclk) disable iff (!arst_n)
    !(log_ce && log_ue))
    else $error("log_ce and log_ue set together");

endmodule

`default_nettype wire

// ==== l2d_params.svh ====
// width macros for the l2 read-return datapath, pulled in with `include by every design and test file
`ifndef L2D_PARAMS_SVH
`define L2D_PARAMS_SVH

// codewords returned per array read
`define L2D_LANES 4
// one codeword is 32 data bits plus 7 check bits
`define L2D_LANE_DATA_W 32
`define L2D_LANE_ECC_W 7
`define L2D_WORD_W 39

// full return segment
`define L2D_DATA_W 128
`define L2D_ECC_W 28
// store/scrub path width
`define L2D_DWORD_W 64

`endif

// ==== l2d_pkg.sv ====
// shared syndrome and error-class types, referenced by scoped name from rtl and testbench
`default_nettype none

`include "l2d_params.svh"

package l2d_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // per-lane syndrome
  ////////////////////////////////////////////////////////////////////////////

  // bit 6 is the overall parity flag
  // bits 5:0 are the hamming check flags (xor of set-bit positions)
  typedef struct packed {
    logic                          parity;
    logic [`L2D_LANE_ECC_W-2:0]    check;
  } lane_synd_t;

  ////////////////////////////////////////////////////////////////////////////
  // read error classification
  ////////////////////////////////////////////////////////////////////////////

  // ue dominates ce when lanes are combined
  typedef enum logic [1:0] {
    ERR_NONE = 2'd0,
    ERR_CE   = 2'd1,
    ERR_UE   = 2'd2
  } err_class_t;

endpackage

`default_nettype wire

// ==== l2d_ret_top.sv ====
// top of the l2 read-return path, joins datapath, error control and error log
`timescale 1ns/1ps
`default_nettype none

`include "l2d_params.svh"

module l2d_ret_top (
  input  logic                     rclk,
  input  logic                     arst_n,
  input  logic                     rd_vld_c7,
  input  logic [`L2D_DATA_W-1:0]   rd_data_c7,
  input  logic [`L2D_ECC_W-1:0]    rd_ecc_c7,
  input  logic                     dword_sel_c7,
  input  logic                     sel_higher_word_c7,
  input  logic                     sel_higher_dword_c7,
  input  logic                     err_clr,
  output logic [`L2D_DATA_W-1:0]   ret_data_c8,
  output logic                     ret_vld_c8,
  output logic [`L2D_DWORD_W-1:0]  arb_data_c8,
  output logic [`L2D_WORD_W-1:0]   diag_data_c7,
  output logic [`L2D_ECC_W-1:0]    lda_syndrome_c9,
  output logic                     ce_c8,
  output logic                     ue_c8,
  output logic                     log_ce,
  output logic                     log_ue,
  output logic [`L2D_ECC_W-1:0]    log_synd
);

  // per-lane syndromes from the correctors to the classifier
  l2d_pkg::lane_synd_t [`L2D_LANES-1:0] lane_synd_c7;

  l2d_deccdp u_deccdp (
    .rclk                (rclk),
    .rd_data_c7          (rd_data_c7),
    .rd_ecc_c7           (rd_ecc_c7),
    .dword_sel_c7        (dword_sel_c7),
    .sel_higher_word_c7  (sel_higher_word_c7),
    .sel_higher_dword_c7 (sel_higher_dword_c7),
    .ret_data_c8         (ret_data_c8),
    .arb_data_c8         (arb_data_c8),
    .diag_data_c7        (diag_data_c7),
    .lane_synd_c7        (lane_synd_c7),
    .lda_syndrome_c9     (lda_syndrome_c9)
  );

  l2d_decc_ctl u_decc_ctl (
    .rclk         (rclk),
    .arst_n       (arst_n),
    .rd_vld_c7    (rd_vld_c7),
    .lane_synd_c7 (lane_synd_c7),
    .ret_vld_c8   (ret_vld_c8),
    .ce_c8        (ce_c8),
    .ue_c8        (ue_c8)
  );

  // log sees the c8 strobes and the c9 syndrome
  l2d_err_log u_err_log (
    .rclk            (rclk),
    .arst_n          (arst_n),
    .ce_c8           (ce_c8),
    .ue_c8           (ue_c8),
    .err_clr         (err_clr),
    .lda_syndrome_c9 (lda_syndrome_c9),
    .log_ce          (log_ce),
    .log_ue          (log_ue),
    .log_synd        (log_synd)
  );

endmodule

`default_nettype wire

// ==== l2d_tb.sv ====
// table-driven testbench for the l2 read-return path, top module l2d_tb compiled from files.f
`timescale 1ns/1ps
`default_nettype none

`include "l2d_params.svh"

module l2d_tb;

  localparam int LANES      = `L2D_LANES;
  localparam int DW         = `L2D_LANE_DATA_W;
  localparam int EW         = `L2D_LANE_ECC_W;
  localparam int WW         = `L2D_WORD_W;
  localparam int MAX_CYCLES = 200;
  localparam int RST_WAIT   = 20;
  // flip byte value meaning no flip in that lane
  localparam int NO_BIT     = 255;
  localparam logic [31:0] NF = 32'hffff_ffff;
  localparam l2d_pkg::err_class_t NONE = l2d_pkg::ERR_NONE;
  localparam l2d_pkg::err_class_t CE   = l2d_pkg::ERR_CE;
  localparam l2d_pkg::err_class_t UE   = l2d_pkg::ERR_UE;

  typedef logic [`L2D_DATA_W-1:0] wide_t;
  typedef logic [`L2D_ECC_W-1:0]  synd_t;

  // ctl is {dword_sel, sel_higher_word, sel_higher_dword, vld, err_clr}
  // fa/fb carry one flipped codeword bit per lane byte, lane 3 in the top byte
  typedef struct packed {
    logic                rnd;
    wide_t               data;
    logic [31:0]         fa;
    logic [31:0]         fb;
    logic [4:0]          ctl;
    l2d_pkg::err_class_t cls;
    l2d_pkg::err_class_t lg;
  } row_t;

  // what one row should show at c8 and c9
  typedef struct packed {
    wide_t               data;
    logic                dsel;
    logic                vld;
    l2d_pkg::err_class_t cls;
    synd_t               synd;
    l2d_pkg::err_class_t lg;
  } exp_t;

  logic                  rclk, arst_n;
  logic                  rd_vld_c7, dword_sel_c7, sel_higher_word_c7, sel_higher_dword_c7;
  logic                  err_clr;
  wide_t                 rd_data_c7, ret_data_c8;
  synd_t                 rd_ecc_c7, lda_syndrome_c9, log_synd;
  logic                  ret_vld_c8, ce_c8, ue_c8, log_ce, log_ue;
  logic [`L2D_DWORD_W-1:0] arb_data_c8;
  logic [WW-1:0]         diag_data_c7;

  row_t                  rows [$];
  exp_t                  q8 [$];
  exp_t                  q9 [$];
  logic [31:0]           lcg_state;
  // log model state
  l2d_pkg::err_class_t   m_log;
  synd_t                 m_synd;
  logic                  clr_prev;

  l2d_tb_clkgen u_clkgen (.rclk(rclk), .arst_n(arst_n));

  l2d_ret_top u_dut (
    .rclk (rclk), .arst_n (arst_n), .rd_vld_c7 (rd_vld_c7), .rd_data_c7 (rd_data_c7),
    .rd_ecc_c7 (rd_ecc_c7), .dword_sel_c7 (dword_sel_c7),
    .sel_higher_word_c7 (sel_higher_word_c7), .sel_higher_dword_c7 (sel_higher_dword_c7),
    .err_clr (err_clr), .ret_data_c8 (ret_data_c8), .ret_vld_c8 (ret_vld_c8),
    .arb_data_c8 (arb_data_c8), .diag_data_c7 (diag_data_c7),
    .lda_syndrome_c9 (lda_syndrome_c9), .ce_c8 (ce_c8), .ue_c8 (ue_c8),
    .log_ce (log_ce), .log_ue (log_ue), .log_synd (log_synd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // hamming position of codeword bit idx, ecc in 0..6 and data in 7..38
  function automatic int hpos(input int idx);
    int p;
    int d;
    p = 0;
    d = -1;
    if (idx == EW - 1) begin
      return 0;
    end
    if (idx < EW - 1) begin
      return 1 << idx;
    end
    // walk the non power-of-two slots until data bit idx-7 is reached
    while (d < idx - EW) begin
      p++;
      if ((p & (p - 1)) != 0) begin
        d++;
      end
    end
    return p;
  endfunction

  function automatic logic [WW-1:0] encode_lane(input logic [DW-1:0] d);
    logic [WW-1:0] cw;
    cw = {d, {EW{1'b0}}};
    for (int j = 0; j < DW; j++) begin
      for (int k = 0; k < EW - 1; k++) begin
        if (d[j] && ((hpos(j + EW) >> k) & 1) != 0) begin
          cw[k] = ~cw[k];
        end
      end
    end
    // overall parity makes the whole word even
    cw[EW-1] = ^cw;
    return cw;
  endfunction

  function automatic l2d_pkg::err_class_t class_of(input logic ce, input logic ue);
    if (ue) begin
      return UE;
    end
    return ce ? CE : NONE;
  endfunction

  task automatic add_row(input logic rnd, input wide_t data, input logic [31:0] fa,
                         input logic [31:0] fb, input logic [4:0] ctl,
                         input l2d_pkg::err_class_t cls, input l2d_pkg::err_class_t lg);
    rows.push_back('{rnd, data, fa, fb, ctl, cls, lg});
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input string name, input wide_t got, input wide_t want);
    if (got !== want) begin
      abort_run($sformatf("ERR %s got %h exp %h", name, got, want));
    end
  endtask

  task automatic check_class(input string name, input l2d_pkg::err_class_t got,
                             input l2d_pkg::err_class_t want);
    if (got !== want) begin
      abort_run($sformatf("ERR %s got %h exp %h", name, got, want));
    end
  endtask

  task automatic check_synd(input string name, input synd_t got, input synd_t want);
    if (got !== want) begin
      abort_run($sformatf("ERR %s got %h exp %h", name, got, want));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_table();
    // clean reads over all four diag selects, back-to-back dword selects
    add_row(1'b1, '0, NF, NF, 5'b0_0_0_1_0, NONE, NONE);
    add_row(1'b1, '0, NF, NF, 5'b1_1_0_1_0, NONE, NONE);
    add_row(1'b1, '0, NF, NF, 5'b0_0_1_1_0, NONE, NONE);
    add_row(1'b1, '0, NF, NF, 5'b1_1_1_1_0, NONE, NONE);
    // singles on a data, a check and the parity position, first ce is logged
    add_row(1'b0, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 32'hffff_ff0c, NF,
            5'b1_0_1_1_0, CE, CE);
    add_row(1'b1, '0, 32'hff03_ffff, NF, 5'b0_1_0_1_0, CE, CE);
    add_row(1'b1, '0, 32'h06ff_ffff, NF, 5'b1_0_0_1_0, CE, CE);
    // double error on an idle cycle raises nothing
    add_row(1'b1, '0, 32'hffff_0aff, 32'hffff_1eff, 5'b0_0_1_0_0, NONE, CE);
    // ue in lane 1 beats a ce in lane 0 and replaces the logged ce
    add_row(1'b1, '0, 32'hffff_0a14, 32'hffff_1eff, 5'b1_1_1_1_0, UE, UE);
    add_row(1'b1, '0, 32'hff26_ffff, NF, 5'b0_1_0_1_0, CE, UE);
    // this ue meets the clear from the next row at the same edge
    add_row(1'b1, '0, 32'h07ff_ffff, 32'h00ff_ffff, 5'b1_0_0_1_0, UE, NONE);
    add_row(1'b1, '0, NF, NF, 5'b0_1_1_1_1, NONE, NONE);
    add_row(1'b1, '0, 32'hffff_05ff, NF, 5'b1_0_1_1_0, CE, CE);
    add_row(1'b1, '0, 32'hffff_ff19, NF, 5'b0_0_0_1_0, CE, NONE);
    add_row(1'b1, '0, 32'hff0f_ffff, NF, 5'b1_1_0_1_1, CE, CE);
    add_row(1'b1, '0, NF, NF, 5'b0_0_1_1_0, NONE, CE);
    add_row(1'b1, '0, 32'hffff_ff00, 32'hffff_ff01, 5'b1_1_1_1_0, UE, UE);
    // a later ue in another lane leaves the logged ue and its syndrome alone
    add_row(1'b1, '0, 32'h0aff_ffff, 32'h1eff_ffff, 5'b1_0_0_1_0, UE, UE);
    // idle tail drains the pipe
    add_row(1'b0, '0, NF, NF, 5'b0_0_0_0_0, NONE, UE);
    add_row(1'b0, '0, NF, NF, 5'b0_0_0_0_0, NONE, UE);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    row_t          r;
    exp_t          e;
    exp_t          d8;
    exp_t          d9;
    wide_t         base;
    wide_t         din;
    synd_t         ein;
    logic [WW-1:0] cw [LANES];
    int            idx;
    int            n;
    int            pos;
    int            lane;
    int            waited;
    logic          has9;
    rd_vld_c7           <= 1'b0;
    rd_data_c7          <= '0;
    rd_ecc_c7           <= '0;
    dword_sel_c7        <= 1'b0;
    sel_higher_word_c7  <= 1'b0;
    sel_higher_dword_c7 <= 1'b0;
    err_clr             <= 1'b0;
    lcg_state = 32'd78;
    m_log     = NONE;
    m_synd    = '0;
    clr_prev  = 1'b0;
    load_table();
    waited = 0;
    while (arst_n !== 1'b1) begin
      if (waited == RST_WAIT) begin
        abort_run("reset was not released in time");
      end
      @(negedge rclk);
      waited++;
    end
    foreach (rows[i]) begin
      r = rows[i];
      e = '0;
      for (int l = 0; l < LANES; l++) begin
        base[l*DW +: DW] = r.rnd ? lcg_next() : r.data[l*DW +: DW];
        cw[l] = encode_lane(base[l*DW +: DW]);
        n   = 0;
        pos = 0;
        for (int f = 0; f < 2; f++) begin
          idx = (f == 0) ? int'(r.fa[l*8 +: 8]) : int'(r.fb[l*8 +: 8]);
          if (idx != NO_BIT) begin
            cw[l][idx] = ~cw[l][idx];
            n++;
            pos = pos ^ hpos(idx);
          end
        end
        din[l*DW +: DW] = cw[l][WW-1:EW];
        ein[l*EW +: EW] = cw[l][EW-1:0];
        e.synd[l*EW +: EW] = {n[0], pos[EW-2:0]};
        // a double error leaves the data as received
        e.data[l*DW +: DW] = (n == 2) ? cw[l][WW-1:EW] : base[l*DW +: DW];
      end
      e.dsel = r.ctl[4];
      e.vld  = r.ctl[1];
      e.cls  = r.cls;
      e.lg   = r.lg;
      @(posedge rclk);
      rd_data_c7          <= din;
      rd_ecc_c7           <= ein;
      dword_sel_c7        <= r.ctl[4];
      sel_higher_word_c7  <= r.ctl[3];
      sel_higher_dword_c7 <= r.ctl[2];
      rd_vld_c7           <= r.ctl[1];
      err_clr             <= r.ctl[0];
      @(negedge rclk);
      // high dword select picks lanes 1/0, high word select the lower lane
      lane = r.ctl[2] ? (r.ctl[3] ? 0 : 1) : (r.ctl[3] ? 2 : 3);
      check_data("diag_data_c7", wide_t'(diag_data_c7), wide_t'(cw[lane]));
      q8.push_back(e);
      q9.push_back(e);
      if (q8.size() > 1) begin
        d8 = q8.pop_front();
        check_data("ret_vld_c8", wide_t'(ret_vld_c8), wide_t'(d8.vld));
        check_data("ret_data_c8", ret_data_c8, d8.data);
        check_data("arb_data_c8", wide_t'(arb_data_c8),
                   wide_t'(d8.dsel ? d8.data[63:0] : d8.data[127:64]));
        check_class("ce_c8/ue_c8", class_of(ce_c8, ue_c8), d8.cls);
      end
      has9 = q9.size() > 2;
      if (has9) begin
        d9 = q9.pop_front();
      end
      // clear from one row back meets the class from two rows back
      if (clr_prev) begin
        m_log  = NONE;
        m_synd = '0;
      end else if (has9 && d9.cls == UE && m_log != UE) begin
        m_log  = UE;
        m_synd = d9.synd;
      end else if (has9 && d9.cls == CE && m_log == NONE) begin
        m_log  = CE;
        m_synd = d9.synd;
      end
      if (has9) begin
        check_synd("lda_syndrome_c9", lda_syndrome_c9, d9.synd);
        check_class("log_ce/log_ue", class_of(log_ce, log_ue), d9.lg);
      end
      check_class("log_ce/log_ue", class_of(log_ce, log_ue), m_log);
      check_synd("log_synd", log_synd, m_synd);
      clr_prev = r.ctl[0];
    end
    $display("Test completed successfully");
    $finish;
  end

  // global cycle limit
  initial begin
    repeat (MAX_CYCLES) @(posedge rclk);
    abort_run("simulation did not finish within the cycle limit");
  end

endmodule

`default_nettype wire

// ==== l2d_tb_clkgen.sv ====
// clock and reset source for the testbench, rclk at 100 ns and arst_n held low for 4 cycles
`timescale 1ns/1ps
`default_nettype none

module l2d_tb_clkgen #(
  parameter int RST_CYCLES = 4
) (
  output logic rclk,
  output logic arst_n
);

  // half of the 100 ns period
  localparam int HALF_NS = 50;

  initial begin
    rclk = 1'b0;
    forever #HALF_NS rclk = ~rclk;
  end

  // release lands on a rising edge, flops still see reset there
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge rclk);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire
